// ==== lsuPkg.sv ====
package lsuPkg;

    // ==================================================================
    // Widths and register map
    // ==================================================================

    localparam int XLEN    = 32;
    localparam int SQN_W   = 7;
    localparam int TAG_W   = 6;
    localparam int RAM_AW  = 8;  // 256 words.
    localparam int WMASK_W = XLEN / 8;
    localparam int FAULT_W = 16;

    localparam logic CFG_CTRL   = 1'b0;
    localparam logic CFG_FAULTS = 1'b1;

    // ==================================================================
    // Types
    // ==================================================================

    typedef enum logic [3:0] {
        NOP,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } lsuOp_t;

    typedef struct packed {
        logic              valid;
        lsuOp_t            opcode;
        logic [XLEN-1:0]   srcA;
        logic [XLEN-1:0]   srcB;
        logic [11:0]       imm;
        logic [SQN_W-1:0]  sqN;
        logic [TAG_W-1:0]  tagDst;
    } exUop_t;

    typedef struct packed {
        logic               valid;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    data;
        logic [WMASK_W-1:0] wmask;
        logic               isLoad;
        logic [1:0]         size;     // 0 byte, 1 half, 2 word.
        logic [1:0]         shamt;    // Byte lane of the load.
        logic               signExtend;
        logic               exception;
        logic [SQN_W-1:0]   sqN;
        logic [TAG_W-1:0]   tagDst;
    } aguUop_t;

    typedef struct packed {
        logic             taken;
        logic [SQN_W-1:0] sqN;
    } branchProv_t;

    typedef struct packed {
        logic checkNull;
        logic checkAlign;
    } lsuCfg_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tagDst;
        logic [XLEN-1:0]  data;
        logic             exception;
    } lsuResult_t;

    // True when sequence number a is younger than b, wrap-safe.
    function automatic logic younger(input logic [SQN_W-1:0] a, input logic [SQN_W-1:0] b);
        logic signed [SQN_W-1:0] diff;
        diff = a - b;
        return diff > 0;
    endfunction

endpackage

// ==== agu.sv ====
`timescale 1ns/1ns

module agu (
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  logic                stall,
    input  lsuPkg::branchProv_t branch,
    input  lsuPkg::lsuCfg_t     cfg,
    input  lsuPkg::exUop_t      inUop,
    output lsuPkg::aguUop_t     outUop
);
    import lsuPkg::*;

    logic [XLEN-1:0] addr;
    logic            nullFault;
    logic            halfFault;
    logic            wordFault;
    logic            take;
    logic            squashHeld;
    aguUop_t         dec;

    // ==================================================================
    // Address and fault checks
    // ==================================================================

    assign addr = inUop.srcA + {{(XLEN-12){inUop.imm[11]}}, inUop.imm};

    assign nullFault = cfg.checkNull && (addr == '0);
    assign halfFault = cfg.checkAlign && addr[0];
    assign wordFault = cfg.checkAlign && (addr[1:0] != 2'b00);

    // Younger than a taken branch never enters.
    assign take = !stall && en && inUop.valid && (inUop.opcode != NOP) &&
                  !(branch.taken && younger(inUop.sqN, branch.sqN));

    assign squashHeld = outUop.valid && branch.taken && younger(outUop.sqN, branch.sqN);

    // ==================================================================
    // Opcode decode
    // ==================================================================

    always_comb begin
        dec            = '0;
        dec.valid      = 1'b1;
        dec.addr       = addr;
        dec.sqN        = inUop.sqN;
        dec.tagDst     = inUop.tagDst;
        dec.data       = inUop.srcB;
        case (inUop.opcode)
            LB, LBU: begin
                dec.isLoad     = 1'b1;
                dec.shamt      = addr[1:0];
                dec.size       = 2'd0;
                dec.signExtend = (inUop.opcode == LB);
                dec.exception  = nullFault;
            end
            LH, LHU: begin
                dec.isLoad     = 1'b1;
                dec.shamt      = {addr[1], 1'b0};
                dec.size       = 2'd1;
                dec.signExtend = (inUop.opcode == LH);
                dec.exception  = nullFault || halfFault;
            end
            LW: begin
                dec.isLoad     = 1'b1;
                dec.shamt      = 2'd0;
                dec.size       = 2'd2;
                dec.exception  = nullFault || wordFault;
            end
            SB: begin
                dec.wmask      = 4'b0001 << addr[1:0];
                dec.data       = inUop.srcB << {addr[1:0], 3'b000};
                dec.exception  = nullFault;
            end
            SH: begin
                dec.wmask      = addr[1] ? 4'b1100 : 4'b0011;
                dec.data       = inUop.srcB << {addr[1], 4'b0000};
                dec.exception  = nullFault || halfFault;
            end
            SW: begin
                dec.wmask      = 4'b1111;
                dec.exception  = nullFault || wordFault;
            end
            default: begin
                dec.valid      = 1'b0;
            end
        endcase
    end

    // ==================================================================
    // Output register
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            outUop.valid <= 1'b0;
        end else if (take) begin
            outUop <= dec;
        end else if (!stall || squashHeld) begin
            outUop.valid <= 1'b0;  // Drained or squashed.
        end
    end

endmodule

// ==== lsuConfig.sv ====
`timescale 1ns/1ns

module lsuConfig (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfgWrite,
    input  logic                    cfgAddr,
    input  logic [lsuPkg::XLEN-1:0] cfgWdata,
    output logic [lsuPkg::XLEN-1:0] cfgRdata,
    input  logic                    faultPulse,
    output lsuPkg::lsuCfg_t         cfg
);
    import lsuPkg::*;

    logic [FAULT_W-1:0] faults;

    // Check-enable register, both checks on out of reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.checkNull  <= 1'b1;
            cfg.checkAlign <= 1'b1;
        end else if (cfgWrite && (cfgAddr == CFG_CTRL)) begin
            cfg.checkNull  <= cfgWdata[0];
            cfg.checkAlign <= cfgWdata[1];
        end
    end

    // Saturating fault counter, cleared by a write.
    always_ff @(posedge clk) begin
        if (rst) begin
            faults <= '0;
        end else if (cfgWrite && (cfgAddr == CFG_FAULTS)) begin
            faults <= '0;
        end else if (faultPulse && (faults != '1)) begin
            faults <= faults + 1'b1;
        end
    end

    always_comb begin
        if (cfgAddr == CFG_CTRL) begin
            cfgRdata = {{(XLEN-2){1'b0}}, cfg.checkAlign, cfg.checkNull};
        end else begin
            cfgRdata = {{(XLEN-FAULT_W){1'b0}}, faults};
        end
    end

endmodule

// ==== dataRam.sv ====
`timescale 1ns/1ns

module dataRam (
    input  logic                       clk,
    input  logic                       we,
    input  logic [lsuPkg::WMASK_W-1:0] wmask,
    input  logic [lsuPkg::RAM_AW-1:0]  addr,
    input  logic [lsuPkg::XLEN-1:0]    wdata,
    output logic [lsuPkg::XLEN-1:0]    rdata
);
    import lsuPkg::*;

    logic [XLEN-1:0] mem [2**RAM_AW];

    // Byte-lane writes.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < WMASK_W; b++) begin
                if (wmask[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, old data on a same-address write.
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// ==== loadAlign.sv ====
`timescale 1ns/1ns

module loadAlign (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  lsuPkg::aguUop_t            inUop,
    output logic                       ramWe,
    output logic [lsuPkg::WMASK_W-1:0] ramWmask,
    output logic [lsuPkg::RAM_AW-1:0]  ramAddr,
    output logic [lsuPkg::XLEN-1:0]    ramWdata,
    input  logic [lsuPkg::XLEN-1:0]    ramRdata,
    output logic                       faultPulse,
    output logic                       storeDone,
    output lsuPkg::lsuResult_t         result
);
    import lsuPkg::*;

    typedef struct packed {
        logic             valid;
        logic [1:0]       shamt;
        logic [1:0]       size;
        logic             signExtend;
        logic             exception;
        logic [TAG_W-1:0] tagDst;
    } readStage_t;

    logic            accept;
    readStage_t      rd;
    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] formatted;

    assign accept     = inUop.valid && !stall;
    assign faultPulse = accept && inUop.exception;

    // ==================================================================
    // RAM port
    // ==================================================================

    assign ramWe    = accept && !inUop.isLoad && !inUop.exception;
    assign ramWmask = inUop.wmask;
    assign ramAddr  = inUop.addr[RAM_AW+1:2];  // Upper bits wrap.
    assign ramWdata = inUop.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            storeDone <= 1'b0;
            rd.valid  <= 1'b0;
        end else begin
            storeDone <= ramWe;
            rd.valid  <= accept && inUop.isLoad;
        end
        rd.shamt      <= inUop.shamt;
        rd.size       <= inUop.size;
        rd.signExtend <= inUop.signExtend;
        rd.exception  <= inUop.exception;
        rd.tagDst     <= inUop.tagDst;
    end

    // ==================================================================
    // Result formatting
    // ==================================================================

    assign shifted = ramRdata >> {rd.shamt, 3'b000};

    always_comb begin
        case (rd.size)
            2'd0:    formatted = {{(XLEN-8){rd.signExtend && shifted[7]}}, shifted[7:0]};
            2'd1:    formatted = {{(XLEN-16){rd.signExtend && shifted[15]}}, shifted[15:0]};
            default: formatted = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= rd.valid;
        end
        result.tagDst    <= rd.tagDst;
        result.exception <= rd.exception;
        result.data      <= rd.exception ? '0 : formatted;  // Faults return zero.
    end

endmodule

// ==== lsuTop.sv ====
`timescale 1ns/1ns

module lsuTop (
    input  logic                    clk,
    input  logic                    rst,
    input  lsuPkg::exUop_t          exUop,
    input  logic                    en,
    input  logic                    stall,
    input  lsuPkg::branchProv_t     branch,
    input  logic                    cfgWrite,
    input  logic                    cfgAddr,
    input  logic [lsuPkg::XLEN-1:0] cfgWdata,
    output logic [lsuPkg::XLEN-1:0] cfgRdata,
    output lsuPkg::lsuResult_t      result,
    output logic                    storeDone
);
    import lsuPkg::*;

    lsuCfg_t            cfg;
    aguUop_t            aguUop;
    logic               ramWe;
    logic [WMASK_W-1:0] ramWmask;
    logic [RAM_AW-1:0]  ramAddr;
    logic [XLEN-1:0]    ramWdata;
    logic [XLEN-1:0]    ramRdata;
    logic               faultPulse;

    lsuConfig cfg_i (
        .clk        (clk),
        .rst        (rst),
        .cfgWrite   (cfgWrite),
        .cfgAddr    (cfgAddr),
        .cfgWdata   (cfgWdata),
        .cfgRdata   (cfgRdata),
        .faultPulse (faultPulse),
        .cfg        (cfg)
    );

    agu agu_i (
        .clk    (clk),
        .rst    (rst),
        .en     (en),
        .stall  (stall),
        .branch (branch),
        .cfg    (cfg),
        .inUop  (exUop),
        .outUop (aguUop)
    );

    dataRam ram_i (
        .clk   (clk),
        .we    (ramWe),
        .wmask (ramWmask),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    loadAlign align_i (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .inUop      (aguUop),
        .ramWe      (ramWe),
        .ramWmask   (ramWmask),
        .ramAddr    (ramAddr),
        .ramWdata   (ramWdata),
        .ramRdata   (ramRdata),
        .faultPulse (faultPulse),
        .storeDone  (storeDone),
        .result     (result)
    );

endmodule

// ==== lsuTb.sv ====
`timescale 1ns/1ns

module lsuTb;
    import lsuPkg::*;

    localparam int FILL_OPS = 16;
    localparam int RAND_OPS = 40;
    localparam int STALL_OPS = 60;
    localparam int NUM_OPS = 2 * FILL_OPS + 2 * RAND_OPS + STALL_OPS + 21;
    localparam int WATCHDOG_CYCLES = (NUM_OPS + 50) * 4;
    localparam logic [31:0] REGION = 32'h100;  // 16 words under test.

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [XLEN-1:0]    data;
        logic               exc;
        logic signed [31:0] cycle;  // -1 when latency is not checked.
    } expLoad_t;

    logic            clk;
    logic            rst;
    exUop_t          exUop;
    logic            en;
    logic            stall;
    branchProv_t     branch;
    logic            cfgWrite;
    logic            cfgAddr;
    logic [XLEN-1:0] cfgWdata;
    logic [XLEN-1:0] cfgRdata;
    lsuResult_t      result;
    logic            storeDone;

    logic [7:0]       shadow [1024];
    expLoad_t         expQ[$];
    expLoad_t         head;
    int               errors;
    int               pendingStores;
    int               expFaults;
    int               cycle;
    logic             tbAlign;
    logic [SQN_W-1:0] sqCnt;
    logic [TAG_W-1:0] tagCnt;
    lsuOp_t           ops [8] = '{LB, LH, LW, LBU, LHU, SB, SH, SW};

    lsuTop dut_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // ==================================================================
    // Reference rules
    // ==================================================================

    function automatic int sizeBytes(input lsuOp_t op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    function automatic logic isLoadOp(input lsuOp_t op);
        return op inside {LB, LH, LW, LBU, LHU};
    endfunction

    function automatic logic isFault(input lsuOp_t op, input logic [31:0] addr);
        logic [31:0] low;
        low = addr & (sizeBytes(op) - 1);
        return (addr == 0) || (tbAlign && low != 0);
    endfunction

    // Misaligned lanes fall back to the naturally aligned base.
    function automatic logic [31:0] loadValue(input lsuOp_t op, input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] v;
        base = addr & ~(sizeBytes(op) - 1);
        v = '0;
        for (int i = 0; i < sizeBytes(op); i++) begin
            v[i*8 +: 8] = shadow[(base + i) & 32'h3FF];
        end
        if (op == LB) v = {{24{v[7]}}, v[7:0]};
        if (op == LH) v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    task automatic writeShadow(input lsuOp_t op, input logic [31:0] addr,
                               input logic [31:0] data);
        logic [31:0] base;
        base = addr & ~(sizeBytes(op) - 1);
        for (int i = 0; i < sizeBytes(op); i++) begin
            shadow[(base + i) & 32'h3FF] = data[i*8 +: 8];
        end
    endtask

    // ==================================================================
    // Stimulus helpers
    // ==================================================================

    task automatic issueOp(input lsuOp_t op, input logic [31:0] addr,
                           input logic [31:0] data, input logic dropped, input logic timed);
        logic [11:0] imm;
        logic [31:0] sext;
        logic        fault;
        expLoad_t    e;
        imm = 12'($urandom);
        sext = {{20{imm[11]}}, imm};
        exUop.valid = 1'b1;
        exUop.opcode = op;
        exUop.srcA = addr - sext;
        exUop.srcB = data;
        exUop.imm = imm;
        exUop.sqN = sqCnt;
        exUop.tagDst = tagCnt;
        if (!dropped) begin
            fault = isFault(op, addr);
            if (fault) expFaults++;
            if (isLoadOp(op)) begin
                e.tag = tagCnt;
                e.data = fault ? 32'h0 : loadValue(op, addr);
                e.exc = fault;
                e.cycle = timed ? cycle + 3 : -1;
                expQ.push_back(e);
            end else if (!fault) begin
                writeShadow(op, addr, data);
                pendingStores++;
            end
        end
        sqCnt++;
        tagCnt++;
        @(negedge clk);
        exUop.valid = 1'b0;
    endtask

    task automatic drain();
        while (expQ.size() != 0 || pendingStores != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic writeReg(input logic a, input logic [31:0] d);
        cfgWrite = 1'b1;
        cfgAddr = a;
        cfgWdata = d;
        @(negedge clk);
        cfgWrite = 1'b0;
    endtask

    task automatic checkReg(input logic a, input logic [31:0] exp);
        cfgAddr = a;
        #10;
        assert (cfgRdata == exp) else begin
            errors++;
            $display("error cfgRdata[%0d]: expected %h, actual %h", a, exp, cfgRdata);
        end
    endtask

    function automatic logic [31:0] randAddr(input lsuOp_t op);
        return REGION + (($urandom % 64) & ~(sizeBytes(op) - 1));
    endfunction

    // ==================================================================
    // Output checks
    // ==================================================================

    always @(negedge clk) begin
        if (!rst && result.valid) begin
            assert (expQ.size() > 0) else begin
                errors++;
                $display("load result appeared with no load outstanding");
            end
            if (expQ.size() > 0) begin
                head = expQ.pop_front();
                assert (result.data == head.data) else begin
                    errors++;
                    $display("error result.data: expected %h, actual %h", head.data, result.data);
                end
                assert (result.tagDst == head.tag) else begin
                    errors++;
                    $display("error result.tagDst: expected %h, actual %h",
                             head.tag, result.tagDst);
                end
                assert (result.exception == head.exc) else begin
                    errors++;
                    $display("error result.exception: expected %h, actual %h",
                             head.exc, result.exception);
                end
                assert (head.cycle < 0 || cycle == head.cycle) else begin
                    errors++;
                    $display("load result came at cycle %0d instead of %0d", cycle, head.cycle);
                end
            end
        end
        if (!rst && storeDone) begin
            assert (pendingStores > 0) else begin
                errors++;
                $display("storeDone pulsed with no store outstanding");
            end
            if (pendingStores > 0) pendingStores--;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial begin
        lsuOp_t op;
        logic [31:0] a;
        void'($urandom(10));
        clk = 1'b0;
        rst = 1'b1;
        exUop = '0;
        en = 1'b0;
        stall = 1'b0;
        branch = '0;
        cfgWrite = 1'b0;
        cfgAddr = 1'b0;
        cfgWdata = '0;
        errors = 0;
        pendingStores = 0;
        expFaults = 0;
        cycle = 0;
        tbAlign = 1'b1;
        sqCnt = '0;
        tagCnt = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        en = 1'b1;

        // Fill region, then random stores and timed loads.
        for (int i = 0; i < FILL_OPS; i++) issueOp(SW, REGION + i * 4, $urandom, 1'b0, 1'b0);
        for (int i = 0; i < RAND_OPS; i++) begin
            op = ops[5 + $urandom % 3];
            issueOp(op, randAddr(op), $urandom, 1'b0, 1'b0);
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            op = ops[$urandom % 5];
            issueOp(op, randAddr(op), 32'h0, 1'b0, 1'b1);
        end
        drain();

        // Faults with both checks on.
        issueOp(SH, REGION + 1, 32'hDEAD_BEEF, 1'b0, 1'b0);
        issueOp(SW, REGION + 6, 32'hCAFE_F00D, 1'b0, 1'b0);
        issueOp(LH, REGION + 3, 32'h0, 1'b0, 1'b1);
        issueOp(LW, REGION + 9, 32'h0, 1'b0, 1'b1);
        issueOp(SB, 32'h0, 32'h0000_00A5, 1'b0, 1'b0);
        issueOp(LB, 32'h0, 32'h0, 1'b0, 1'b1);
        for (int i = 0; i < 3; i++) issueOp(LW, REGION + i * 4, 32'h0, 1'b0, 1'b1);
        drain();
        checkReg(CFG_FAULTS, expFaults);

        // Alignment check off.
        writeReg(CFG_CTRL, 32'h1);
        tbAlign = 1'b0;
        checkReg(CFG_CTRL, 32'h1);
        issueOp(SH, REGION + 5, 32'h1234_8765, 1'b0, 1'b0);
        issueOp(SW, REGION + 10, 32'h89AB_CDEF, 1'b0, 1'b0);
        issueOp(LH, REGION + 7, 32'h0, 1'b0, 1'b1);
        issueOp(LHU, REGION + 5, 32'h0, 1'b0, 1'b1);
        issueOp(LW, REGION + 11, 32'h0, 1'b0, 1'b1);
        issueOp(LW, REGION + 4, 32'h0, 1'b0, 1'b1);
        drain();
        checkReg(CFG_FAULTS, expFaults);
        writeReg(CFG_CTRL, 32'h3);
        tbAlign = 1'b1;

        // Branch squash at the input and in the held register.
        branch = '{taken: 1'b1, sqN: sqCnt - 7'd2};
        issueOp(SW, REGION + 20, 32'h5555_AAAA, 1'b1, 1'b0);
        branch = '{taken: 1'b1, sqN: sqCnt + 7'd3};
        issueOp(SW, REGION + 24, 32'h0F0F_1234, 1'b0, 1'b0);
        branch = '0;
        issueOp(SW, REGION + 28, 32'h7777_1111, 1'b1, 1'b0);
        stall = 1'b1;
        branch = '{taken: 1'b1, sqN: sqCnt - 7'd3};
        @(negedge clk);
        branch = '0;
        stall = 1'b0;
        for (int i = 20; i < 32; i += 4) issueOp(LW, REGION + i, 32'h0, 1'b0, 1'b1);
        drain();

        // Random stall and en.
        for (int i = 0; i < STALL_OPS; i++) begin
            stall = ($urandom % 3) == 0;
            en = ($urandom % 4) != 0;
            op = ops[$urandom % 8];
            a = randAddr(op);
            issueOp(op, a, $urandom, stall || !en, 1'b0);
        end
        stall = 1'b0;
        en = 1'b1;
        for (int i = 0; i < FILL_OPS; i++) issueOp(LW, REGION + i * 4, 32'h0, 1'b0, 1'b0);
        drain();

        $display("errors: %0d, loads outstanding: %0d, stores outstanding: %0d",
                 errors, expQ.size(), pendingStores);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
lsuPkg.sv
agu.sv
lsuConfig.sv
dataRam.sv
loadAlign.sv
lsuTop.sv
lsuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsuTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf $(OBJDIR)
